/* vlog.f */
common/stq_pkg.sv
stq/stq_alloc.sv
stq/stq_entry_array.sv
stq/stq_fwd.sv
stq/stq_drain.sv
source/stq_top.sv
bench/stq_assertions.sv
bench/tb_stq.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     := --binary --assert --timing
TOP       := tb_stq
FILELIST  := vlog.f
OBJDIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --assert --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

/* bench/tb_stq.sv */
`timescale 1ns/1ps

module tb_stq
  import stq_pkg::*;
();

  localparam int STQ_SIZE = 8;
  localparam int IDX_W    = $clog2(STQ_SIZE);

  logic                i_clk = 1'b0;
  logic                i_reset_n;
  logic                i_disp_valid;
  size_t               i_disp_size;
  logic                o_full;
  logic [IDX_W-1:0]    o_disp_idx;
  logic                i_st_valid;
  logic [IDX_W-1:0]    i_st_idx;
  logic [PADDR_W-1:0]  i_st_paddr;
  logic [DW_W-1:0]     i_st_data;
  logic                i_commit_valid;
  logic                i_ld_valid;
  logic [PADDR_W-1:0]  i_ld_paddr;
  size_t               i_ld_size;
  logic [IDX_W-1:0]    i_ld_stq_idx;
  logic                o_fwd_valid;
  logic [DW_BYTES-1:0] o_fwd_be;
  logic [DW_W-1:0]     o_fwd_data;
  logic                o_stb_valid;
  logic [PADDR_W-1:0]  o_stb_paddr;
  logic [DW_BYTES-1:0] o_stb_strb;
  logic [DW_W-1:0]     o_stb_data;
  logic                i_stb_ready;

  // Mirror queue with the DUT's slot numbering
  int                  m_head = 0;
  int                  m_count = 0;
  int                  m_ncommit = 0;       // Committed slots are a prefix from the head
  bit                  m_addr_valid [STQ_SIZE];
  logic [PADDR_W-1:0]  m_paddr [STQ_SIZE];
  size_t               m_size [STQ_SIZE];
  logic [DW_W-1:0]     m_data [STQ_SIZE];
  int                  total_alloc = 0;
  int                  total_drained = 0;
  logic [31:0]         rng_state = 32'd90;
  int                  ready_left = 0;      // Cycles left in the current ready stretch

  stq_top #(.STQ_SIZE(STQ_SIZE)) dut_i (.*);

  always #2 i_clk = ~i_clk;

  // ==============================
  // Helpers and reference model
  // ==============================
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  task automatic next_rand(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  task automatic next_cycle;
    @(posedge i_clk);
    #0.5;
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("FAIL time=%0t %s got=%0h expected=%0h", $time, name, got, exp);
      $display("Simulation failed");
      $fatal(1, "Output mismatch");
    end
  endtask

  // Naturally aligned address in a few doublewords on two pages
  function automatic logic [PADDR_W-1:0] rand_addr(input size_t s, input logic [31:0] r);
    logic [2:0] align;
    logic [2:0] off;
    align = 3'((1 << int'(s)) - 1);
    off   = r[2:0] & ~align;
    return 32'h0000_1000 | {27'd0, r[4:3], off} | (r[10] ? 32'h0010_0000 : 32'h0);
  endfunction

  // Bytes touched by an access of 1, 2, 4 or 8 bytes at the address offset
  function automatic logic [DW_BYTES-1:0] exp_strb(input size_t s,
                                                   input logic [PADDR_W-1:0] a);
    logic [DW_BYTES-1:0] strb;
    int                  off;
    int                  nbytes;
    off    = int'(a[2:0]);
    nbytes = 1 << int'(s);
    strb   = '0;
    for (int b = 0; b < DW_BYTES; b++) begin
      strb[b] = (b >= off) && (b < off + nbytes);
    end
    return strb;
  endfunction

  // Byte b of the result is byte b-off of the store data
  function automatic logic [DW_W-1:0] exp_data(input logic [DW_W-1:0] d, input logic [2:0] off);
    logic [DW_W-1:0] res;
    res = '0;
    for (int b = 0; b < DW_BYTES; b++) begin
      if (b >= int'(off)) res[b*8 +: 8] = d[(b - int'(off))*8 +: 8];
    end
    return res;
  endfunction

  function automatic bit exp_stb_valid();
    return (m_count > 0) && (m_ncommit > 0) && m_addr_valid[m_head];
  endfunction

  // Youngest older store that writes each byte
  function automatic void fwd_ref(input logic [PADDR_W-1:0] ld_paddr, input size_t ld_size,
                                  input int ld_age, output logic [DW_BYTES-1:0] be,
                                  output logic [DW_W-1:0] data);
    logic [DW_BYTES-1:0] ld_mask;
    logic [DW_BYTES-1:0] st_mask;
    logic [DW_W-1:0]     st_data;
    int                  idx;
    bit                  hit;
    ld_mask = exp_strb(ld_size, ld_paddr);
    be      = '0;
    data    = '0;
    for (int b = 0; b < DW_BYTES; b++) begin
      hit = 1'b0;
      for (int a = ld_age - 1; a >= 0; a--) begin
        idx = (m_head + a) % STQ_SIZE;
        if (!hit && ld_mask[b] && a < m_count && m_addr_valid[idx] &&
            m_paddr[idx][PADDR_W-1:DW_OFF_W] == ld_paddr[PADDR_W-1:DW_OFF_W]) begin
          st_mask = exp_strb(m_size[idx], m_paddr[idx]);
          if (st_mask[b]) begin
            hit          = 1'b1;
            be[b]        = 1'b1;
            st_data      = exp_data(m_data[idx], m_paddr[idx][DW_OFF_W-1:0]);
            data[b*8 +: 8] = st_data[b*8 +: 8];
          end
        end
      end
    end
  endfunction

  // ==============================
  // Mirror update and compare
  // ==============================
  always @(posedge i_clk) begin : mirror_update
    bit accept;
    bit alloc;
    bit commit;
    int tail;
    if (!i_reset_n) begin
      m_head    = 0;
      m_count   = 0;
      m_ncommit = 0;
    end else begin
      accept = exp_stb_valid() && i_stb_ready;
      alloc  = i_disp_valid && (m_count < STQ_SIZE);
      commit = i_commit_valid && (m_ncommit < m_count);
      tail   = (m_head + m_count) % STQ_SIZE;
      if (i_st_valid) begin
        m_addr_valid[i_st_idx] = 1'b1;
        m_paddr[i_st_idx]      = i_st_paddr;
        m_data[i_st_idx]       = i_st_data;
      end
      if (alloc) begin
        m_addr_valid[tail] = 1'b0;
        m_size[tail]       = i_disp_size;
        total_alloc++;
      end
      if (commit) m_ncommit++;
      if (accept) begin
        m_head = (m_head + 1) % STQ_SIZE;
        m_count--;
        m_ncommit--;
      end
      if (alloc) m_count++;
    end
  end

  task automatic compare_outputs;
    logic [DW_BYTES-1:0] be;
    logic [DW_W-1:0]     data;
    logic [DW_W-1:0]     bmask;
    bit                  sv;
    int                  ld_age;
    sv = exp_stb_valid();
    check("o_full", 64'(o_full), 64'(m_count == STQ_SIZE));
    check("o_disp_idx", 64'(o_disp_idx), 64'((m_head + m_count) % STQ_SIZE));
    check("o_stb_valid", 64'(o_stb_valid), 64'(sv));
    if (sv) begin
      check("o_stb_paddr", 64'(o_stb_paddr),
            64'(m_paddr[m_head] & ~PADDR_W'(DW_BYTES - 1)));
      check("o_stb_strb", 64'(o_stb_strb), 64'(exp_strb(m_size[m_head], m_paddr[m_head])));
      check("o_stb_data", o_stb_data,
            exp_data(m_data[m_head], m_paddr[m_head][DW_OFF_W-1:0]));
    end
    be   = '0;
    data = '0;
    if (i_ld_valid) begin
      ld_age = (int'(i_ld_stq_idx) - m_head + STQ_SIZE) % STQ_SIZE;
      fwd_ref(i_ld_paddr, i_ld_size, ld_age, be, data);
    end
    for (int b = 0; b < DW_BYTES; b++) bmask[b*8 +: 8] = {8{be[b]}};
    check("o_fwd_valid", 64'(o_fwd_valid), 64'(be != '0));
    check("o_fwd_be", 64'(o_fwd_be), 64'(be));
    check("o_fwd_data", o_fwd_data & bmask, data);  // Only forwarded bytes matter
  endtask

  always @(negedge i_clk) begin
    if (i_reset_n) begin
      compare_outputs();
      if (o_stb_valid && i_stb_ready) total_drained++;  // Handshakes seen at the DUT
    end
  end

  // ==============================
  // Stimulus
  // ==============================
  task automatic drive_inputs(input int disp_pct, input int st_pct, input int commit_pct,
                              input bit ready_always);
    logic [31:0] r;
    int          idx;
    int          age;
    bit          found;
    next_rand(r);
    i_disp_valid = int'(r % 100) < disp_pct;
    i_disp_size  = size_t'(r[9:8]);
    next_rand(r);
    found      = 1'b0;
    i_st_valid = 1'b0;
    if (int'(r % 100) < st_pct) begin
      for (int k = 0; k < STQ_SIZE; k++) begin
        age = (int'(r[15:13]) + k) % STQ_SIZE;
        idx = (m_head + age) % STQ_SIZE;
        if (!found && age < m_count && !m_addr_valid[idx]) begin  // Still waiting on execute
          found      = 1'b1;
          i_st_valid = 1'b1;
          i_st_idx   = IDX_W'(idx);
          i_st_paddr = rand_addr(m_size[idx], r >> 16);
        end
      end
    end
    next_rand(r);
    i_st_data[63:32] = r;
    next_rand(r);
    i_st_data[31:0] = r;
    next_rand(r);
    i_commit_valid = (m_ncommit < m_count) && (int'(r % 100) < commit_pct);
    if (ready_always) begin
      i_stb_ready = 1'b1;
    end else begin
      if (ready_left == 0) begin
        next_rand(r);
        i_stb_ready = r[0];
        ready_left  = 1 + int'(r[4:1]);
      end
      ready_left--;
    end
    next_rand(r);
    i_ld_valid   = r[1:0] != 2'b00;
    i_ld_size    = size_t'(r[3:2]);
    i_ld_paddr   = rand_addr(i_ld_size, r >> 8);
    age          = int'(r[31:28]) % ((m_count < STQ_SIZE ? m_count : STQ_SIZE - 1) + 1);
    i_ld_stq_idx = IDX_W'((m_head + age) % STQ_SIZE);
  endtask

  task automatic wait_for_full(input int max_cycles);
    int n;
    n = 0;
    while (!o_full) begin
      if (n == max_cycles) begin
        $display("ERROR: queue did not report full after %0d dispatches", max_cycles);
        $display("Simulation failed");
        $fatal(1, "Timeout");
      end
      drive_inputs(100, 0, 0, 1'b1);
      next_cycle();
      n++;
    end
  endtask

  task automatic run_until_empty(input int st_pct, input int commit_pct, input int max_cycles);
    int n;
    n = 0;
    while (m_count != 0) begin
      if (n == max_cycles) begin
        $display("ERROR: store queue did not drain within %0d cycles", max_cycles);
        $display("Simulation failed");
        $fatal(1, "Timeout");
      end
      drive_inputs(0, st_pct, commit_pct, 1'b1);
      next_cycle();
      n++;
    end
  endtask

  initial begin
    i_reset_n      = 1'b0;
    i_disp_valid   = 1'b0;
    i_disp_size    = SIZE_B;
    i_st_valid     = 1'b0;
    i_st_idx       = '0;
    i_st_paddr     = '0;
    i_st_data      = '0;
    i_commit_valid = 1'b0;
    i_ld_valid     = 1'b0;
    i_ld_paddr     = '0;
    i_ld_size      = SIZE_B;
    i_ld_stq_idx   = '0;
    i_stb_ready    = 1'b0;
    repeat (10) @(posedge i_clk);
    #0.5;
    i_reset_n = 1'b1;
    check("o_disp_idx", 64'(o_disp_idx), 64'(0));
    check("o_stb_valid", 64'(o_stb_valid), 64'(0));
    check("o_full", 64'(o_full), 64'(0));

    wait_for_full(STQ_SIZE + 4);
    repeat (3) begin  // Dispatch while full is dropped
      drive_inputs(100, 0, 0, 1'b1);
      next_cycle();
    end
    run_until_empty(100, 100, 100);

    repeat (4000) begin
      drive_inputs(50, 40, 40, 1'b0);
      next_cycle();
    end
    run_until_empty(60, 60, 500);

    i_disp_valid   = 1'b0;
    i_st_valid     = 1'b0;
    i_commit_valid = 1'b0;
    i_ld_valid     = 1'b0;
    next_cycle();
    check("total_drained", 64'(total_drained), 64'(total_alloc));
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* bench/stq_assertions.sv */
`timescale 1ns/1ps

module stq_assertions
  import stq_pkg::*;
#(
  parameter int STQ_SIZE = 8
) (
  input logic                i_clk,
  input logic                i_reset_n,
  input logic                i_commit_valid,
  input logic                i_full,
  input logic                i_stb_valid,
  input logic                i_stb_ready,
  input logic [PADDR_W-1:0]  i_stb_paddr,
  input logic [DW_BYTES-1:0] i_stb_strb,
  input logic [DW_W-1:0]     i_stb_data,
  input logic [STQ_SIZE-1:0] i_valid,
  input logic [STQ_SIZE-1:0] i_committed
);

  // ==============================
  // Store buffer handshake
  // ==============================
  a_stb_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_stb_valid && !i_stb_ready |=> i_stb_valid && $stable(i_stb_paddr) &&
                                    $stable(i_stb_strb) && $stable(i_stb_data))
    else $error("store buffer request changed while stalled");

  a_reset_idle: assert property (@(posedge i_clk)
    $rose(i_reset_n) |-> !i_stb_valid && !i_full)
    else $error("store buffer valid or full set right after reset");

  // Commit needs a valid entry that is not committed yet
  a_commit_target: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_commit_valid |-> |(i_valid & ~i_committed))
    else $error("commit with no uncommitted entry");

endmodule

bind stq_top stq_assertions #(.STQ_SIZE(STQ_SIZE)) u_assertions (
  .i_clk          (i_clk),
  .i_reset_n      (i_reset_n),
  .i_commit_valid (i_commit_valid),
  .i_full         (o_full),
  .i_stb_valid    (o_stb_valid),
  .i_stb_ready    (i_stb_ready),
  .i_stb_paddr    (o_stb_paddr),
  .i_stb_strb     (o_stb_strb),
  .i_stb_data     (o_stb_data),
  .i_valid        (w_valid),
  .i_committed    (w_committed)
);

/* source/stq_top.sv */
`timescale 1ns/1ps

module stq_top
  import stq_pkg::*;
#(
  parameter int STQ_SIZE = 8,
  localparam int IDX_W = $clog2(STQ_SIZE)
) (
  input  logic                i_clk,
  input  logic                i_reset_n,

  // Dispatch
  input  logic                i_disp_valid,
  input  size_t               i_disp_size,
  output logic                o_full,
  output logic [IDX_W-1:0]    o_disp_idx,

  // Store execute
  input  logic                i_st_valid,
  input  logic [IDX_W-1:0]    i_st_idx,
  input  logic [PADDR_W-1:0]  i_st_paddr,
  input  logic [DW_W-1:0]     i_st_data,

  input  logic                i_commit_valid,

  // Load forwarding
  input  logic                i_ld_valid,
  input  logic [PADDR_W-1:0]  i_ld_paddr,
  input  size_t               i_ld_size,
  input  logic [IDX_W-1:0]    i_ld_stq_idx,
  output logic                o_fwd_valid,
  output logic [DW_BYTES-1:0] o_fwd_be,
  output logic [DW_W-1:0]     o_fwd_data,

  // Store buffer
  output logic                o_stb_valid,
  output logic [PADDR_W-1:0]  o_stb_paddr,
  output logic [DW_BYTES-1:0] o_stb_strb,
  output logic [DW_W-1:0]     o_stb_data,
  input  logic                i_stb_ready
);

  logic                w_alloc;
  logic                w_release;
  logic [IDX_W-1:0]    w_head_idx;
  logic [STQ_SIZE-1:0] w_valid;
  logic [STQ_SIZE-1:0] w_addr_valid;
  logic [STQ_SIZE-1:0] w_committed;
  logic [PADDR_W-1:0]  w_paddr [STQ_SIZE];
  size_t               w_size  [STQ_SIZE];
  logic [DW_W-1:0]     w_data  [STQ_SIZE];

  stq_alloc #(.STQ_SIZE(STQ_SIZE)) u_alloc (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_disp_valid (i_disp_valid),
    .i_release    (w_release),
    .o_alloc      (w_alloc),
    .o_disp_idx   (o_disp_idx),
    .o_head_idx   (w_head_idx),
    .o_full       (o_full)
  );

  stq_entry_array #(.STQ_SIZE(STQ_SIZE)) u_entries (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_alloc        (w_alloc),
    .i_alloc_idx    (o_disp_idx),
    .i_alloc_size   (i_disp_size),
    .i_st_valid     (i_st_valid),
    .i_st_idx       (i_st_idx),
    .i_st_paddr     (i_st_paddr),
    .i_st_data      (i_st_data),
    .i_commit_valid (i_commit_valid),
    .i_release      (w_release),
    .i_head_idx     (w_head_idx),
    .o_valid        (w_valid),
    .o_addr_valid   (w_addr_valid),
    .o_committed    (w_committed),
    .o_paddr        (w_paddr),
    .o_size         (w_size),
    .o_data         (w_data)
  );

  stq_fwd #(.STQ_SIZE(STQ_SIZE)) u_fwd (
    .i_ld_valid   (i_ld_valid),
    .i_ld_paddr   (i_ld_paddr),
    .i_ld_size    (i_ld_size),
    .i_ld_stq_idx (i_ld_stq_idx),
    .i_head_idx   (w_head_idx),
    .i_valid      (w_valid),
    .i_addr_valid (w_addr_valid),
    .i_paddr      (w_paddr),
    .i_size       (w_size),
    .i_data       (w_data),
    .o_fwd_valid  (o_fwd_valid),
    .o_fwd_be     (o_fwd_be),
    .o_fwd_data   (o_fwd_data)
  );

  stq_drain #(.STQ_SIZE(STQ_SIZE)) u_drain (
    .i_head_idx   (w_head_idx),
    .i_valid      (w_valid),
    .i_addr_valid (w_addr_valid),
    .i_committed  (w_committed),
    .i_paddr      (w_paddr),
    .i_size       (w_size),
    .i_data       (w_data),
    .i_stb_ready  (i_stb_ready),
    .o_stb_valid  (o_stb_valid),
    .o_stb_paddr  (o_stb_paddr),
    .o_stb_strb   (o_stb_strb),
    .o_stb_data   (o_stb_data),
    .o_release    (w_release)
  );

endmodule

/* stq/stq_drain.sv */
`timescale 1ns/1ps

module stq_drain
  import stq_pkg::*;
#(
  parameter int STQ_SIZE = 8,
  localparam int IDX_W = $clog2(STQ_SIZE)
) (
  input  logic [IDX_W-1:0]    i_head_idx,
  input  logic [STQ_SIZE-1:0] i_valid,
  input  logic [STQ_SIZE-1:0] i_addr_valid,
  input  logic [STQ_SIZE-1:0] i_committed,
  input  logic [PADDR_W-1:0]  i_paddr [STQ_SIZE],
  input  size_t               i_size  [STQ_SIZE],
  input  logic [DW_W-1:0]     i_data  [STQ_SIZE],

  // Store buffer
  input  logic                i_stb_ready,
  output logic                o_stb_valid,
  output logic [PADDR_W-1:0]  o_stb_paddr,
  output logic [DW_BYTES-1:0] o_stb_strb,
  output logic [DW_W-1:0]     o_stb_data,

  output logic                o_release
);

  logic [PADDR_W-1:0]  w_head_paddr;
  logic [DW_OFF_W-1:0] w_head_off;

  // ==============================
  // Head entry
  // ==============================
  assign w_head_paddr = i_paddr[i_head_idx];
  assign w_head_off   = w_head_paddr[DW_OFF_W-1:0];

  assign o_stb_valid = i_valid[i_head_idx] && i_committed[i_head_idx] &&
                       i_addr_valid[i_head_idx];

  // Doubleword aligned request
  assign o_stb_paddr = {w_head_paddr[PADDR_W-1:DW_OFF_W], {DW_OFF_W{1'b0}}};
  assign o_stb_strb  = size_mask(i_size[i_head_idx]) << w_head_off;
  assign o_stb_data  = i_data[i_head_idx] << {w_head_off, 3'b000};

  assign o_release = o_stb_valid && i_stb_ready;  // Handshake done

endmodule

/* stq/stq_fwd.sv */
`timescale 1ns/1ps

module stq_fwd
  import stq_pkg::*;
#(
  parameter int STQ_SIZE = 8,
  localparam int IDX_W = $clog2(STQ_SIZE)
) (
  // Load lookup
  input  logic                i_ld_valid,
  input  logic [PADDR_W-1:0]  i_ld_paddr,
  input  size_t               i_ld_size,
  input  logic [IDX_W-1:0]    i_ld_stq_idx,  // Tail index seen at load dispatch

  input  logic [IDX_W-1:0]    i_head_idx,
  input  logic [STQ_SIZE-1:0] i_valid,
  input  logic [STQ_SIZE-1:0] i_addr_valid,
  input  logic [PADDR_W-1:0]  i_paddr [STQ_SIZE],
  input  size_t               i_size  [STQ_SIZE],
  input  logic [DW_W-1:0]     i_data  [STQ_SIZE],

  output logic                o_fwd_valid,
  output logic [DW_BYTES-1:0] o_fwd_be,
  output logic [DW_W-1:0]     o_fwd_data
);

  logic [IDX_W-1:0]    w_ld_age;
  logic [DW_BYTES-1:0] w_ld_mask;
  logic [IDX_W-1:0]    w_rot_idx  [STQ_SIZE];  // Entry index by age
  logic [STQ_SIZE-1:0] w_rot_qual;
  logic [DW_BYTES-1:0] w_rot_mask [STQ_SIZE];
  logic [DW_W-1:0]     w_rot_data [STQ_SIZE];

  assign w_ld_age  = i_ld_stq_idx - i_head_idx;
  assign w_ld_mask = size_mask(i_ld_size) << i_ld_paddr[DW_OFF_W-1:0];

  // ==============================
  // Age ordered candidates
  // ==============================
  for (genvar a = 0; a < STQ_SIZE; a++) begin : g_age
    logic same_dw;

    assign w_rot_idx[a] = i_head_idx + IDX_W'(a);
    assign same_dw = i_paddr[w_rot_idx[a]][PADDR_W-1:DW_OFF_W] ==
                     i_ld_paddr[PADDR_W-1:DW_OFF_W];

    // Older than the load, address known, same doubleword
    assign w_rot_qual[a] = i_ld_valid && (IDX_W'(a) < w_ld_age) &&
                           i_valid[w_rot_idx[a]] && i_addr_valid[w_rot_idx[a]] && same_dw;

    assign w_rot_mask[a] = (size_mask(i_size[w_rot_idx[a]]) <<
                            i_paddr[w_rot_idx[a]][DW_OFF_W-1:0]) & w_ld_mask;
    assign w_rot_data[a] = i_data[w_rot_idx[a]] <<
                           {i_paddr[w_rot_idx[a]][DW_OFF_W-1:0], 3'b000};
  end

  // ==============================
  // Per byte youngest match
  // ==============================
  always_comb begin
    o_fwd_be   = '0;
    o_fwd_data = '0;
    for (int b = 0; b < DW_BYTES; b++) begin
      for (int a = 0; a < STQ_SIZE; a++) begin
        if (w_rot_qual[a] && w_rot_mask[a][b]) begin  // Later age overrides
          o_fwd_be[b]          = 1'b1;
          o_fwd_data[b*8 +: 8] = w_rot_data[a][b*8 +: 8];
        end
      end
    end
  end

  assign o_fwd_valid = |o_fwd_be;

endmodule

/* stq/stq_entry_array.sv */
`timescale 1ns/1ps

module stq_entry_array
  import stq_pkg::*;
#(
  parameter int STQ_SIZE = 8,
  localparam int IDX_W = $clog2(STQ_SIZE)
) (
  input  logic                i_clk,
  input  logic                i_reset_n,

  // Allocation from dispatch
  input  logic                i_alloc,
  input  logic [IDX_W-1:0]    i_alloc_idx,
  input  size_t               i_alloc_size,

  // Execute update
  input  logic                i_st_valid,
  input  logic [IDX_W-1:0]    i_st_idx,
  input  logic [PADDR_W-1:0]  i_st_paddr,
  input  logic [DW_W-1:0]     i_st_data,

  input  logic                i_commit_valid,
  input  logic                i_release,
  input  logic [IDX_W-1:0]    i_head_idx,

  output logic [STQ_SIZE-1:0] o_valid,
  output logic [STQ_SIZE-1:0] o_addr_valid,
  output logic [STQ_SIZE-1:0] o_committed,
  output logic [PADDR_W-1:0]  o_paddr [STQ_SIZE],
  output size_t               o_size  [STQ_SIZE],
  output logic [DW_W-1:0]     o_data  [STQ_SIZE]
);

  logic [STQ_SIZE-1:0] w_commit_oh;

  // ==============================
  // Commit target
  // ==============================
  // Oldest valid entry not yet committed, scanning from the head
  always_comb begin : commit_sel
    logic [IDX_W-1:0] idx;
    logic             found;
    w_commit_oh = '0;
    found       = 1'b0;
    for (int a = 0; a < STQ_SIZE; a++) begin
      idx = i_head_idx + IDX_W'(a);
      if (!found && o_valid[idx] && !o_committed[idx]) begin
        found            = 1'b1;
        w_commit_oh[idx] = i_commit_valid;
      end
    end
  end

  // ==============================
  // Entry flags
  // ==============================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_valid      <= '0;
      o_addr_valid <= '0;
      o_committed  <= '0;
    end else begin
      for (int e = 0; e < STQ_SIZE; e++) begin
        if (i_alloc && (i_alloc_idx == IDX_W'(e))) begin
          o_valid[e]      <= 1'b1;
          o_addr_valid[e] <= 1'b0;
          o_committed[e]  <= 1'b0;
        end else if (i_release && (i_head_idx == IDX_W'(e))) begin
          o_valid[e] <= 1'b0;
        end
        if (i_st_valid && (i_st_idx == IDX_W'(e))) begin
          o_addr_valid[e] <= 1'b1;
        end
        if (w_commit_oh[e]) begin
          o_committed[e] <= 1'b1;
        end
      end
    end
  end

  // Payload
  always_ff @(posedge i_clk) begin
    if (i_alloc) begin
      o_size[i_alloc_idx] <= i_alloc_size;
    end
    if (i_st_valid) begin
      o_paddr[i_st_idx] <= i_st_paddr;
      o_data[i_st_idx]  <= i_st_data;
    end
  end

endmodule

/* stq/stq_alloc.sv */
`timescale 1ns/1ps

module stq_alloc #(
  parameter int STQ_SIZE = 8,
  localparam int IDX_W = $clog2(STQ_SIZE)
) (
  input  logic             i_clk,
  input  logic             i_reset_n,

  input  logic             i_disp_valid,
  input  logic             i_release,    // Head entry leaves the queue

  output logic             o_alloc,
  output logic [IDX_W-1:0] o_disp_idx,
  output logic [IDX_W-1:0] o_head_idx,
  output logic             o_full
);

  // ==============================
  // Pointers
  // ==============================
  // Extra MSB tells full from empty when the indices match
  logic [IDX_W:0] r_tail;
  logic [IDX_W:0] r_head;

  assign o_full = (r_tail[IDX_W] != r_head[IDX_W]) &&
                  (r_tail[IDX_W-1:0] == r_head[IDX_W-1:0]);

  assign o_alloc = i_disp_valid && !o_full;  // Dispatch while full is dropped

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_tail <= '0;
    end else if (o_alloc) begin
      r_tail <= r_tail + 1'b1;
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head <= '0;
    end else if (i_release) begin
      r_head <= r_head + 1'b1;
    end
  end

  assign o_disp_idx = r_tail[IDX_W-1:0];
  assign o_head_idx = r_head[IDX_W-1:0];

endmodule

/* common/stq_pkg.sv */
package stq_pkg;

  // ==============================
  // Widths
  // ==============================
  localparam int PADDR_W  = 32;            // Physical address
  localparam int DW_BYTES = 8;             // Bytes per doubleword
  localparam int DW_W     = DW_BYTES * 8;  // Doubleword data width
  localparam int DW_OFF_W = $clog2(DW_BYTES);

  // ==============================
  // Access size
  // ==============================
  typedef enum logic [1:0] {
    SIZE_B  = 2'b00,  // 1 byte
    SIZE_H  = 2'b01,  // 2 bytes
    SIZE_W  = 2'b10,  // 4 bytes
    SIZE_DW = 2'b11   // 8 bytes
  } size_t;

  // Unshifted byte mask, bit 0 is the lowest addressed byte
  function automatic logic [DW_BYTES-1:0] size_mask(input size_t size);
    logic [DW_BYTES-1:0] mask;
    case (size)
      SIZE_B:  mask = 8'h01;
      SIZE_H:  mask = 8'h03;
      SIZE_W:  mask = 8'h0f;
      SIZE_DW: mask = 8'hff;
      default: mask = 8'h00;
    endcase
    return mask;
  endfunction

endpackage
